// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_neighbor_info
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
source/gnn_cfg_pkg.sv
source/neighbor_info_pkg.sv
source/request_fifo.sv
source/neighbor_info_ctrl.sv
source/neighbor_info_bank.sv
source/neighbor_out_stage.sv
source/neighbor_info_integration.sv
verification/tb_neighbor_info.sv

// File: source/gnn_cfg_pkg.sv
`default_nettype none

package gnn_cfg_pkg;

    // fixed sizes of the accelerator, shared by every block.
    localparam int node_id_w     = 8;
    localparam int pe_tag_w      = 3;
    localparam int replay_iter_w = 2;
    localparam int nb_info_w     = 17;

    typedef logic [node_id_w-1:0]     node_id_t;
    typedef logic [pe_tag_w-1:0]      pe_tag_t;
    typedef logic [replay_iter_w-1:0] replay_iter_t;
    typedef logic [nb_info_w-1:0]     nb_info_t;   // one neighbor-info word, used as an address.

endpackage

`default_nettype wire

// File: source/neighbor_info_bank.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_info_bank #(
    parameter int num_banks  = 4,
    parameter int bank_index = 0
) (
    input  logic                        clk,
    input  neighbor_info_pkg::nb_read_t rd_cmd,
    input  neighbor_info_pkg::nb_load_t load,
    output gnn_cfg_pkg::nb_info_t       q
);
    import gnn_cfg_pkg::*;
    import neighbor_info_pkg::*;

    localparam int unsigned rows_per_iter = (2 ** node_id_w) / num_banks;
    localparam int unsigned depth         = rows_per_iter * (2 ** replay_iter_w);
    localparam int          addr_w        = $clog2(depth);

    nb_info_t          mem [depth];
    logic              rd_hit;
    logic              ld_hit;
    logic [addr_w-1:0] ld_addr;

    assign rd_hit  = rd_cmd.valid && (rd_cmd.bank == nb_bank_t'(bank_index));
    assign ld_hit  = load.valid && (nb_bank_t'(load.node_id % num_banks) == nb_bank_t'(bank_index));
    // same row layout as the controller, iteration above the node's row.
    assign ld_addr = addr_w'(load.replay_iter * rows_per_iter + load.node_id / num_banks);

    always_ff @(posedge clk) begin
        if (ld_hit) begin
            mem[ld_addr] <= load.data;
        end
        if (rd_hit) begin
            q <= mem[rd_cmd.row[addr_w-1:0]];   // one-cycle synchronous read.
        end
    end

endmodule

`default_nettype wire

// File: source/neighbor_info_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_info_ctrl #(
    parameter int num_banks = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           empty,
    input  neighbor_info_pkg::nb_request_t head,
    input  gnn_cfg_pkg::replay_iter_t      current_replay_iter,
    input  logic                           drain,
    output logic                           pop,
    output neighbor_info_pkg::nb_read_t    rd_cmd
);
    import gnn_cfg_pkg::*;
    import neighbor_info_pkg::*;

    // rows of one bank that belong to a single replay iteration.
    localparam int unsigned rows_per_iter = (2 ** node_id_w) / num_banks;

    logic [1:0] credits;
    logic       issue;
    nb_read_t   next_cmd;

    // while pop is high the head still shows the request already taken,
    // so a new one is only picked in the cycle after.
    assign issue = !empty && !pop && (credits != 2'd0);

    always_comb begin
        next_cmd.valid  = 1'b1;
        next_cmd.bank   = nb_bank_t'(head.node_id % num_banks);
        next_cmd.row    = nb_row_t'(current_replay_iter) * nb_row_t'(rows_per_iter)
                        + nb_row_t'(head.node_id / num_banks);
        next_cmd.pe_tag = head.pe_tag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop    <= 1'b0;
            rd_cmd <= '0;
        end else begin
            pop    <= issue;   // pop and command leave together.
            rd_cmd <= issue ? next_cmd : nb_read_t'('0);
        end
    end

    // one credit per slot of the two-entry result queue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= 2'd2;
        end else begin
            case ({issue, drain})
                2'b10: begin
                    credits <= credits - 2'd1;
                end
                2'b01: begin
                    credits <= credits + 2'd1;
                end
                default: begin
                    credits <= credits;   // none moved, or one spent and one returned.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/neighbor_info_integration.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_info_integration #(
    parameter int fifo_depth = 8,
    parameter int num_banks  = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid,
    input  neighbor_info_pkg::nb_request_t req,
    input  gnn_cfg_pkg::replay_iter_t      current_replay_iter,
    input  logic                           downstream_full,
    input  neighbor_info_pkg::nb_load_t    load,
    output logic                           request_full,
    output logic                           out_valid,
    output neighbor_info_pkg::nb_result_t  out
);
    import gnn_cfg_pkg::*;
    import neighbor_info_pkg::*;

    logic                      fifo_empty;
    logic                      pop;
    logic                      drain;
    nb_request_t               head;
    nb_read_t                  rd_cmd;
    nb_info_t [num_banks-1:0]  bank_data;

    // req_valid writes directly, the FIFO drops it when full.
    request_fifo #(
        .fifo_depth (fifo_depth)
    ) request_fifo_0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (req_valid),
        .wr_data (req),
        .pop     (pop),
        .head    (head),
        .empty   (fifo_empty),
        .full    (request_full)
    );

    neighbor_info_ctrl #(
        .num_banks (num_banks)
    ) neighbor_info_ctrl_0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .empty               (fifo_empty),
        .head                (head),
        .current_replay_iter (current_replay_iter),
        .drain               (drain),
        .pop                 (pop),
        .rd_cmd              (rd_cmd)
    );

    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        neighbor_info_bank #(
            .num_banks  (num_banks),
            .bank_index (i)
        ) neighbor_info_bank_i (
            .clk    (clk),
            .rd_cmd (rd_cmd),
            .load   (load),
            .q      (bank_data[i])
        );
    end

    neighbor_out_stage #(
        .num_banks (num_banks)
    ) neighbor_out_stage_0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_cmd          (rd_cmd),
        .bank_data       (bank_data),
        .downstream_full (downstream_full),
        .out_valid       (out_valid),
        .out             (out),
        .drain           (drain)
    );

endmodule

`default_nettype wire

// File: source/neighbor_info_pkg.sv
`default_nettype none

package neighbor_info_pkg;

    localparam int nb_bank_w = 4;   // enough for up to 16 banks.
    localparam int nb_row_w  = gnn_cfg_pkg::node_id_w + gnn_cfg_pkg::replay_iter_w;

    typedef logic [nb_bank_w-1:0] nb_bank_t;
    typedef logic [nb_row_w-1:0]  nb_row_t;

    // one request from an edge processing element.
    typedef struct packed {
        gnn_cfg_pkg::node_id_t node_id;
        gnn_cfg_pkg::pe_tag_t  pe_tag;
    } nb_request_t;

    // the read command is broadcast, each bank checks the bank field itself.
    typedef struct packed {
        logic                 valid;
        nb_bank_t             bank;
        nb_row_t              row;
        gnn_cfg_pkg::pe_tag_t pe_tag;
    } nb_read_t;

    typedef struct packed {
        gnn_cfg_pkg::nb_info_t addr;
        gnn_cfg_pkg::pe_tag_t  pe_tag;
    } nb_result_t;

    typedef struct packed {
        logic                      valid;
        gnn_cfg_pkg::replay_iter_t replay_iter;
        gnn_cfg_pkg::node_id_t     node_id;
        gnn_cfg_pkg::nb_info_t     data;
    } nb_load_t;

endpackage

`default_nettype wire

// File: source/neighbor_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_out_stage #(
    parameter int num_banks = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  neighbor_info_pkg::nb_read_t             rd_cmd,
    input  gnn_cfg_pkg::nb_info_t [num_banks-1:0]   bank_data,
    input  logic                                    downstream_full,
    output logic                                    out_valid,
    output neighbor_info_pkg::nb_result_t           out,
    output logic                                    drain
);
    import gnn_cfg_pkg::*;
    import neighbor_info_pkg::*;

    logic       cmd_valid;
    nb_bank_t   cmd_bank;
    pe_tag_t    cmd_tag;
    nb_result_t entries [2];
    nb_result_t result;
    logic       wr_sel;
    logic       rd_sel;
    logic [1:0] count;

    // the command is held for one cycle, in step with the bank read.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= rd_cmd.valid;
        end
    end

    always_ff @(posedge clk) begin
        cmd_bank <= rd_cmd.bank;
        cmd_tag  <= rd_cmd.pe_tag;
    end

    assign result.addr   = bank_data[cmd_bank];
    assign result.pe_tag = cmd_tag;

    // the credits upstream keep this queue from overflowing.
    assign out_valid = (count != 2'd0) && !downstream_full;
    assign out       = entries[rd_sel];
    assign drain     = out_valid;

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            entries[wr_sel] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (cmd_valid) begin
                wr_sel <= ~wr_sel;
            end
            if (out_valid) begin
                rd_sel <= ~rd_sel;
            end
            count <= count + 2'(cmd_valid) - 2'(out_valid);
        end
    end

endmodule

`default_nettype wire

// File: source/request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module request_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  neighbor_info_pkg::nb_request_t wr_data,
    input  logic                          pop,
    output neighbor_info_pkg::nb_request_t head,
    output logic                          empty,
    output logic                          full
);
    import neighbor_info_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);

    nb_request_t       mem [fifo_depth];
    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   rd_ptr;
    logic              do_write;
    logic              do_read;

    // a request that finds the FIFO full is simply lost.
    assign do_write = wr_en && !full;
    assign do_read  = pop && !empty;

    // the extra pointer bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign head = mem[rd_ptr[addr_w-1:0]];   // oldest entry, no read latency.

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[addr_w-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_neighbor_info.sv
`timescale 1ns/1ps
`default_nettype none

module tb_neighbor_info;
    import gnn_cfg_pkg::*;
    import neighbor_info_pkg::*;

    localparam int fifo_depth       = 8;
    localparam int num_banks        = 4;
    localparam int half_period      = 50;
    localparam int drive_delay      = 10;
    localparam int pipe_latency     = 4;     // request write to out_valid on an idle pipeline.
    localparam int num_phases       = 5;
    localparam int cycles_per_phase = 2000;
    localparam int max_outstanding  = 6;
    localparam int drain_limit      = 300;

    typedef enum logic [1:0] {stall_off, stall_random, stall_held} stall_mode_t;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    nb_request_t  req;
    replay_iter_t current_replay_iter;
    logic         downstream_full;
    nb_load_t     load;
    logic         request_full;
    logic         out_valid;
    nb_result_t   out;

    nb_info_t     word_table [2**replay_iter_w][2**node_id_w];
    nb_result_t   exp_q [$];
    int           exp_cycle [$];
    int           cycle_count;
    int           stored_count;    // requests accepted while downstream_full is held.
    int           dropped_count;
    logic         pending_store;
    logic         hold_phase;
    logic         full_check_on;
    logic         latency_check_on;
    stall_mode_t  stall_mode;

    neighbor_info_integration #(
        .fifo_depth (fifo_depth),
        .num_banks  (num_banks)
    ) dut0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .req_valid           (req_valid),
        .req                 (req),
        .current_replay_iter (current_replay_iter),
        .downstream_full     (downstream_full),
        .load                (load),
        .request_full        (request_full),
        .out_valid           (out_valid),
        .out                 (out)
    );

    always #(half_period) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic nb_result_t expected_result(input node_id_t node, input pe_tag_t tag,
                                                   input replay_iter_t iter);
        nb_result_t r;
        r.addr   = word_table[iter][node];
        r.pe_tag = tag;
        return r;
    endfunction

    // with downstream_full held, the two credits let exactly two requests leave the FIFO.
    function automatic logic fifo_full_model();
        return hold_phase && (stored_count >= fifo_depth + 2);
    endfunction

    function automatic node_id_t random_node();
        return node_id_t'($urandom_range(0, 2**node_id_w - 1));
    endfunction

    function automatic pe_tag_t random_tag();
        return pe_tag_t'($urandom_range(0, 2**pe_tag_w - 1));
    endfunction

    function automatic replay_iter_t random_iter();
        return replay_iter_t'($urandom_range(0, 2**replay_iter_w - 1));
    endfunction

    task automatic halt_on_error();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        halt_on_error();
    endtask

    task automatic check_result(input nb_result_t actual, input nb_result_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: out expected addr=%h tag=%0d, got addr=%h tag=%0d",
                     $time, expected.addr, expected.pe_tag, actual.addr, actual.pe_tag);
            halt_on_error();
        end
    endtask

    task automatic check_full(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: request_full expected %b, got %b",
                     $time, expected, actual);
            halt_on_error();
        end
    endtask

    // every input change happens a short delay after the rising edge.
    task automatic next_slot();
        @(posedge clk);
        #(drive_delay);
        if (pending_store) begin
            stored_count++;   // the write took place at this edge.
        end
        pending_store = 1'b0;
        req_valid     = 1'b0;
        load          = '0;
        case (stall_mode)
            stall_random: downstream_full = 1'($urandom_range(0, 1));
            stall_held:   downstream_full = 1'b1;
            default:      downstream_full = 1'b0;
        endcase
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_slot();
    endtask

    task automatic load_word(input replay_iter_t iter, input node_id_t node, input nb_info_t data);
        next_slot();
        load.valid       = 1'b1;
        load.replay_iter = iter;
        load.node_id     = node;
        load.data        = data;
        word_table[iter][node] = data;
    endtask

    task automatic send_request(input node_id_t node, input pe_tag_t tag,
                                input replay_iter_t iter);
        next_slot();
        req_valid           = 1'b1;
        req.node_id         = node;
        req.pe_tag          = tag;
        current_replay_iter = iter;
        if (fifo_full_model()) begin
            dropped_count++;   // a full FIFO loses the request.
        end else begin
            exp_q.push_back(expected_result(node, tag, iter));
            exp_cycle.push_back(cycle_count);
            pending_store = 1'b1;
        end
    endtask

    task automatic wait_for_room();
        while (exp_q.size() >= max_outstanding) begin
            next_slot();
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= drain_limit) begin
                report_failure($sformatf("%0d results missing after %0d cycles",
                                         exp_q.size(), drain_limit));
            end else begin
                next_slot();
                waited++;
            end
        end
        idle_cycles(2);   // lets the last credit return.
    endtask

    task automatic send_single(input node_id_t node, input pe_tag_t tag, input replay_iter_t iter);
        send_request(node, tag, iter);
        wait_drained();
        idle_cycles($urandom_range(0, 2));
    endtask

    task automatic load_all_words();
        for (int it = 0; it < 2**replay_iter_w; it++) begin
            for (int n = 0; n < 2**node_id_w; n++) begin
                load_word(replay_iter_t'(it), node_id_t'(n), nb_info_t'($urandom));
            end
        end
        idle_cycles(1);
    endtask

    task automatic run_bursts();
        replay_iter_t iter;
        iter = random_iter();
        repeat (60) begin
            // the iteration is read when the request leaves the FIFO,
            // so it changes only after earlier requests were answered.
            if ($urandom_range(0, 3) == 0) begin
                wait_drained();
                iter = random_iter();
            end
            wait_for_room();
            if ($urandom_range(0, 4) == 0) begin
                idle_cycles(1);
            end
            send_request(random_node(), random_tag(), iter);
        end
        wait_drained();
    endtask

    task automatic run_random_stall();
        replay_iter_t iter;
        iter = random_iter();
        stall_mode = stall_random;
        repeat (80) begin
            wait_for_room();
            if ($urandom_range(0, 1) == 1) begin
                send_request(random_node(), random_tag(), iter);
            end else begin
                idle_cycles(1);
            end
        end
        wait_drained();
        stall_mode      = stall_off;
        downstream_full = 1'b0;
    endtask

    task automatic run_full_hold();
        replay_iter_t iter;
        iter = random_iter();
        stall_mode = stall_held;
        idle_cycles(1);
        stored_count  = 0;
        dropped_count = 0;
        hold_phase    = 1'b1;
        repeat (24) begin
            send_request(random_node(), random_tag(), iter);
        end
        idle_cycles(5);
        if (dropped_count == 0) begin
            report_failure("no request was dropped while the FIFO was held full");
        end
        full_check_on = 1'b0;   // the FIFO empties at its own pace once released.
        hold_phase    = 1'b0;
        stall_mode    = stall_off;
        wait_drained();
        idle_cycles(10);
        full_check_on = 1'b1;
    endtask

    task automatic run_overwrite();
        replay_iter_t iters [16];
        node_id_t     nodes [16];
        for (int i = 0; i < 16; i++) begin
            iters[i] = random_iter();
            nodes[i] = random_node();
            load_word(iters[i], nodes[i], nb_info_t'($urandom));
        end
        idle_cycles(1);
        for (int i = 0; i < 16; i++) begin
            send_single(nodes[i], random_tag(), iters[i]);
        end
        repeat (16) begin
            send_single(random_node(), random_tag(), random_iter());
        end
    endtask

    // outputs are sampled mid-cycle, where they are stable.
    always @(negedge clk) begin
        if (rst_n) begin
            if (full_check_on) begin
                check_full(request_full, fifo_full_model());
            end
            if (out_valid) begin
                if (downstream_full) begin
                    report_failure("out_valid was high while downstream_full was high");
                end else if (exp_q.size() == 0) begin
                    report_failure("out_valid came with no result expected");
                end else begin
                    check_result(out, exp_q[0]);
                    if (latency_check_on && (cycle_count - exp_cycle[0] != pipe_latency)) begin
                        report_failure($sformatf("out_valid came %0d cycles after req_valid",
                                                 cycle_count - exp_cycle[0]));
                    end
                    void'(exp_q.pop_front());
                    void'(exp_cycle.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (num_phases * cycles_per_phase) @(posedge clk);
        report_failure($sformatf("run did not finish within %0d cycles",
                                 num_phases * cycles_per_phase));
    end

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        req_valid           = 1'b0;
        req                 = '0;
        current_replay_iter = '0;
        downstream_full     = 1'b0;
        load                = '0;
        cycle_count         = 0;
        stored_count        = 0;
        dropped_count       = 0;
        pending_store       = 1'b0;
        hold_phase          = 1'b0;
        full_check_on       = 1'b1;
        latency_check_on    = 1'b0;
        stall_mode          = stall_off;
        void'($urandom(19));
        repeat (2) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;

        $display("phase 1: table load and single requests");
        load_all_words();
        latency_check_on = 1'b1;
        repeat (32) begin
            send_single(random_node(), random_tag(), random_iter());
        end
        latency_check_on = 1'b0;

        $display("phase 2: bursts with changing replay iteration");
        run_bursts();
        $display("phase 3: random downstream stalls");
        run_random_stall();
        $display("phase 4: downstream held full");
        run_full_hold();

        $display("phase 5: overwrite and read back");
        latency_check_on = 1'b1;
        run_overwrite();
        idle_cycles(10);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
